/* filelist.f */
+incdir+.
rv_pkg.sv
rv_decoder.sv
rv_reg_file.sv
rv_alu.sv
rv_div_unit.sv
rv_core.sv
tb_clock_gen.sv
tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, the log decides the result
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f filelist.f \
  && ./obj_dir/Vtb_rv_core > sim.log 2>&1 || echo "build or run error" >> sim.log
cat sim.log
grep -qx "sim passed" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

/* rv_alu.sv */
`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_alu (
  input  rv_pkg::alu_op_t i_op,
  input  rv_pkg::word_t   i_a,
  input  rv_pkg::word_t   i_b,
  output rv_pkg::word_t   o_result
);

  logic [4:0]       shamt;
  logic             sub_mode;
  rv_pkg::word_t    b_in;
  logic [`RV_XLEN:0] sum_ext;
  logic             lt_u;
  logic             lt_s;

  assign shamt = i_b[4:0];

  // One adder for add, subtract and both compares
  assign sub_mode = (i_op == rv_pkg::ALU_SUB) ||
                    (i_op == rv_pkg::ALU_SLT) ||
                    (i_op == rv_pkg::ALU_SLTU);
  assign b_in     = sub_mode ? ~i_b : i_b;
  assign sum_ext  = {1'b0, i_a} + {1'b0, b_in} + {{`RV_XLEN{1'b0}}, sub_mode};

  // No carry out of a - b means a borrow
  assign lt_u = ~sum_ext[`RV_XLEN];

  // Signs differ, the negative one is smaller
  assign lt_s = (i_a[`RV_XLEN-1] != i_b[`RV_XLEN-1]) ? i_a[`RV_XLEN-1]
                                                     : sum_ext[`RV_XLEN-1];

  always_comb begin
    case (i_op)
      rv_pkg::ALU_ADD,
      rv_pkg::ALU_SUB: begin
        o_result = sum_ext[`RV_XLEN-1:0];
      end
      rv_pkg::ALU_SLL: begin
        o_result = i_a << shamt;
      end
      rv_pkg::ALU_SLT: begin
        o_result = {{(`RV_XLEN-1){1'b0}}, lt_s};
      end
      rv_pkg::ALU_SLTU: begin
        o_result = {{(`RV_XLEN-1){1'b0}}, lt_u};
      end
      rv_pkg::ALU_XOR: begin
        o_result = i_a ^ i_b;
      end
      rv_pkg::ALU_SRL: begin
        o_result = i_a >> shamt;
      end
      rv_pkg::ALU_SRA: begin
        o_result = $signed(i_a) >>> shamt;
      end
      rv_pkg::ALU_OR: begin
        o_result = i_a | i_b;
      end
      rv_pkg::ALU_AND: begin
        o_result = i_a & i_b;
      end
      default: begin
        // Unused codes, decoder never emits them
        o_result = '0;
      end
    endcase
  end

endmodule

/* rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Datapath and register file sizes
`define RV_XLEN      32
`define RV_NUM_REGS  32
`define RV_REG_IDX_W 5

// Major opcodes handled by the core
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_REG_IMM 7'b0010011
`define RV_OPC_REG_REG 7'b0110011
`define RV_OPC_SYSTEM  7'b1110011

// funct7 values, ALT selects SUB and SRA
`define RV_F7_BASE   7'b0000000
`define RV_F7_ALT    7'b0100000
`define RV_F7_MULDIV 7'b0000001

// funct3 values of the ALU group
`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SR   3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

`endif

/* rv_core.sv */
`timescale 1ns/1ps

module rv_core (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_insn_valid,
  input  rv_pkg::insn_t    i_insn,
  output logic             o_wb_valid,
  output rv_pkg::reg_idx_t o_wb_rd,
  output rv_pkg::word_t    o_wb_data,
  output logic             o_illegal,
  output logic             o_halt
);

  logic             accept;
  logic             halt_q;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  rv_pkg::word_t    imm;
  logic             use_imm;
  rv_pkg::alu_op_t  alu_op;
  rv_pkg::div_op_t  div_op;
  logic             sel_div;
  logic             sel_imm;
  logic             wr_en;
  logic             dec_illegal;
  logic             dec_ecall;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    alu_b;
  rv_pkg::word_t    alu_result;
  rv_pkg::word_t    div_result;
  rv_pkg::word_t    wb_data;

  // No back-pressure, only halt blocks new instructions
  assign accept = i_insn_valid && !halt_q;

  rv_decoder u_decoder (
    .i_insn    (i_insn),
    .i_accept  (accept),
    .o_rs1     (rs1),
    .o_rs2     (rs2),
    .o_rd      (rd),
    .o_imm     (imm),
    .o_use_imm (use_imm),
    .o_alu_op  (alu_op),
    .o_div_op  (div_op),
    .o_sel_div (sel_div),
    .o_sel_imm (sel_imm),
    .o_wr_en   (wr_en),
    .o_illegal (dec_illegal),
    .o_ecall   (dec_ecall)
  );

  rv_reg_file u_reg_file (
    .clk        (clk),
    .rst        (rst),
    .i_we       (wr_en),
    .i_rd       (rd),
    .i_rd_data  (wb_data),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  assign alu_b = use_imm ? imm : rs2_data;

  rv_alu u_alu (
    .i_op     (alu_op),
    .i_a      (rs1_data),
    .i_b      (alu_b),
    .o_result (alu_result)
  );

  rv_div_unit u_div_unit (
    .i_op       (div_op),
    .i_dividend (rs1_data),
    .i_divisor  (rs2_data),
    .o_result   (div_result)
  );

  // LUI takes the upper immediate as is
  assign wb_data = sel_imm ? imm : (sel_div ? div_result : alu_result);

  // Control flags, halt stays set until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      o_wb_valid <= 1'b0;
      o_illegal  <= 1'b0;
      halt_q     <= 1'b0;
    end else begin
      o_wb_valid <= wr_en;
      o_illegal  <= dec_illegal;
      if (dec_ecall) begin
        halt_q <= 1'b1;
      end
    end
  end

  // Writeback report, same edge as the register file write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      o_wb_rd   <= rd;
      o_wb_data <= wb_data;
    end
  end

  assign o_halt = halt_q;

endmodule

/* rv_decoder.sv */
`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_decoder (
  input  rv_pkg::insn_t    i_insn,
  input  logic             i_accept,
  output rv_pkg::reg_idx_t o_rs1,
  output rv_pkg::reg_idx_t o_rs2,
  output rv_pkg::reg_idx_t o_rd,
  output rv_pkg::word_t    o_imm,
  output logic             o_use_imm,
  output rv_pkg::alu_op_t  o_alu_op,
  output rv_pkg::div_op_t  o_div_op,
  output logic             o_sel_div,
  output logic             o_sel_imm,
  output logic             o_wr_en,
  output logic             o_illegal,
  output logic             o_ecall
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  rv_pkg::alu_op_t base_op;
  logic            legal;
  logic            writes;
  logic            is_ecall;

  assign opcode = i_insn[6:0];
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];
  assign o_rd   = i_insn[11:7];
  assign o_rs1  = i_insn[19:15];
  assign o_rs2  = i_insn[24:20];

  // Plain ALU op per funct3, alternate forms patched below
  always_comb begin
    case (funct3)
      `RV_F3_ADD:  base_op = rv_pkg::ALU_ADD;
      `RV_F3_SLL:  base_op = rv_pkg::ALU_SLL;
      `RV_F3_SLT:  base_op = rv_pkg::ALU_SLT;
      `RV_F3_SLTU: base_op = rv_pkg::ALU_SLTU;
      `RV_F3_XOR:  base_op = rv_pkg::ALU_XOR;
      `RV_F3_SR:   base_op = rv_pkg::ALU_SRL;
      `RV_F3_OR:   base_op = rv_pkg::ALU_OR;
      default:     base_op = rv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    legal     = 1'b0;
    writes    = 1'b0;
    is_ecall  = 1'b0;
    o_use_imm = 1'b0;
    o_sel_div = 1'b0;
    o_sel_imm = 1'b0;
    o_alu_op  = base_op;
    // DIV, DIVU, REM, REMU sit at funct3 100 to 111
    o_div_op  = funct3[1:0];
    o_imm     = {{20{i_insn[31]}}, i_insn[31:20]};
    case (opcode)
      `RV_OPC_LUI: begin
        legal     = 1'b1;
        writes    = 1'b1;
        o_sel_imm = 1'b1;
        o_imm     = {i_insn[31:12], 12'b0};
      end
      `RV_OPC_REG_IMM: begin
        writes    = 1'b1;
        o_use_imm = 1'b1;
        legal     = 1'b1;
        // Shift immediates carry funct7 in the upper imm bits
        if (funct3 == `RV_F3_SLL) begin
          legal = (funct7 == `RV_F7_BASE);
        end else if (funct3 == `RV_F3_SR) begin
          legal = (funct7 == `RV_F7_BASE) || (funct7 == `RV_F7_ALT);
          if (funct7 == `RV_F7_ALT) begin
            o_alu_op = rv_pkg::ALU_SRA;
          end
        end
      end
      `RV_OPC_REG_REG: begin
        writes = 1'b1;
        if (funct7 == `RV_F7_BASE) begin
          legal = 1'b1;
        end else if (funct7 == `RV_F7_ALT) begin
          legal    = (funct3 == `RV_F3_ADD) || (funct3 == `RV_F3_SR);
          o_alu_op = (funct3 == `RV_F3_ADD) ? rv_pkg::ALU_SUB : rv_pkg::ALU_SRA;
        end else if (funct7 == `RV_F7_MULDIV) begin
          // Only the divide half, multiplies are rejected
          legal     = funct3[2];
          o_sel_div = 1'b1;
        end
      end
      `RV_OPC_SYSTEM: begin
        legal    = (i_insn[31:7] == 25'd0);
        is_ecall = legal;
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  assign o_wr_en   = i_accept && legal && writes && (o_rd != '0);
  assign o_illegal = i_accept && !legal;
  assign o_ecall   = i_accept && is_ecall;

endmodule

/* rv_div_unit.sv */
`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_div_unit (
  input  rv_pkg::div_op_t i_op,
  input  rv_pkg::word_t   i_dividend,
  input  rv_pkg::word_t   i_divisor,
  output rv_pkg::word_t   o_result
);

  logic              is_signed;
  logic              is_rem;
  logic              neg_dvd;
  logic              neg_dvs;
  rv_pkg::word_t     mag_dividend;
  rv_pkg::word_t     mag_divisor;
  rv_pkg::word_t     u_quo;
  rv_pkg::word_t     u_rem;
  rv_pkg::word_t     quo;
  rv_pkg::word_t     rem;
  logic [`RV_XLEN:0] shifted;
  logic [`RV_XLEN:0] trial;

  assign is_signed = (i_op == rv_pkg::DIV_OP_DIV) || (i_op == rv_pkg::DIV_OP_REM);
  assign is_rem    = (i_op == rv_pkg::DIV_OP_REM) || (i_op == rv_pkg::DIV_OP_REMU);

  // Magnitudes feed the unsigned core
  assign neg_dvd      = is_signed && i_dividend[`RV_XLEN-1];
  assign neg_dvs      = is_signed && i_divisor[`RV_XLEN-1];
  assign mag_dividend = neg_dvd ? (~i_dividend + 1'b1) : i_dividend;
  assign mag_divisor  = neg_dvs ? (~i_divisor + 1'b1) : i_divisor;

  // Restoring division, one quotient bit per step, MSB first
  always_comb begin
    u_rem   = '0;
    u_quo   = mag_dividend;
    shifted = '0;
    trial   = '0;
    for (int i = 0; i < `RV_XLEN; i++) begin
      shifted = {u_rem, u_quo[`RV_XLEN-1]};
      trial   = shifted - {1'b0, mag_divisor};
      if (!trial[`RV_XLEN]) begin
        // Divisor fits, keep the difference
        u_rem = trial[`RV_XLEN-1:0];
        u_quo = {u_quo[`RV_XLEN-2:0], 1'b1};
      end else begin
        u_rem = shifted[`RV_XLEN-1:0];
        u_quo = {u_quo[`RV_XLEN-2:0], 1'b0};
      end
    end
  end

  // Quotient sign from both operands, remainder follows the dividend.
  // Most negative / -1 gives 2^31 and remainder 0, already the wanted result
  assign quo = (neg_dvd != neg_dvs) ? (~u_quo + 1'b1) : u_quo;
  assign rem = neg_dvd ? (~u_rem + 1'b1) : u_rem;

  always_comb begin
    if (i_divisor == '0) begin
      // Fixed results for a zero divisor
      o_result = is_rem ? i_dividend : '1;
    end else if (is_rem) begin
      o_result = rem;
    end else begin
      o_result = quo;
    end
  end

endmodule

/* rv_pkg.sv */
`include "rv_cfg.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]      word_t;
  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;
  typedef logic [31:0]              insn_t;
  typedef logic [3:0]               alu_op_t;
  typedef logic [1:0]               div_op_t;

  // ALU operation codes
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;

  // Divide codes line up with the low two funct3 bits
  localparam div_op_t DIV_OP_DIV  = 2'b00;
  localparam div_op_t DIV_OP_DIVU = 2'b01;
  localparam div_op_t DIV_OP_REM  = 2'b10;
  localparam div_op_t DIV_OP_REMU = 2'b11;

endpackage

/* rv_reg_file.sv */
`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_reg_file (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_we,
  input  rv_pkg::reg_idx_t i_rd,
  input  rv_pkg::word_t    i_rd_data,
  input  rv_pkg::reg_idx_t i_rs1,
  input  rv_pkg::reg_idx_t i_rs2,
  output rv_pkg::word_t    o_rs1_data,
  output rv_pkg::word_t    o_rs2_data
);

  // x1 to x31 only, x0 has no storage
  rv_pkg::word_t regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  // Combinational reads so a write is visible next cycle
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk
);

  // 10 ns period
  initial o_clk = 1'b0;
  always #5 o_clk = ~o_clk;

endmodule

/* tb_rv_core.sv */
`timescale 1ns/1ps

`include "rv_cfg.svh"

module tb_rv_core;

  localparam int N_RR = 200;
  localparam int N_RI = 200;
  localparam int N_DIV = 100;
  localparam int N_ILL = 20;
  localparam int N_HALT = 20;
  // Total steps of all tests including three register sweeps and an idle step per test
  localparam int N_INSNS = 3 * 31 + N_RR + 2 + N_RI + 15 + N_DIV + N_ILL + 1 + N_HALT + 6;
  localparam int CYCLE_LIMIT = N_INSNS + 100;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic clk;
  logic rst;
  logic i_insn_valid;
  rv_pkg::insn_t i_insn;
  logic o_wb_valid;
  rv_pkg::reg_idx_t o_wb_rd;
  rv_pkg::word_t o_wb_data;
  logic o_illegal;
  logic o_halt;

  rv_pkg::word_t model_regs [32];
  logic model_halt;
  logic exp_wr;
  logic exp_ill;
  rv_pkg::reg_idx_t exp_rd;
  rv_pkg::word_t exp_data;
  logic [31:0] lfsr;
  int cycles;
  string test_name;
  int test_checks;
  int test_errors;
  int n_tests;
  int total_checks;
  int total_errors;

  tb_clock_gen u_clock_gen (.o_clk(clk));

  rv_core uut (
    .clk          (clk),
    .rst          (rst),
    .i_insn_valid (i_insn_valid),
    .i_insn       (i_insn),
    .o_wb_valid   (o_wb_valid),
    .o_wb_rd      (o_wb_rd),
    .o_wb_data    (o_wb_data),
    .o_illegal    (o_illegal),
    .o_halt       (o_halt)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? LFSR_TAPS : 32'h0);
  endfunction

  // One LFSR step per returned bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic rv_pkg::insn_t enc_i(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
                                          input logic [2:0] f3, input rv_pkg::reg_idx_t rd);
    return {imm, rs1, f3, rd, `RV_OPC_REG_IMM};
  endfunction

  function automatic rv_pkg::insn_t enc_r(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
                                          input rv_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                          input rv_pkg::reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, `RV_OPC_REG_REG};
  endfunction

  function automatic rv_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
                                              input rv_pkg::word_t a, input rv_pkg::word_t b);
    rv_pkg::word_t r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // funct3 bit 0 marks unsigned and bit 1 marks remainder
  function automatic rv_pkg::word_t div_model(input logic [2:0] f3, input rv_pkg::word_t a,
                                              input rv_pkg::word_t b);
    if (b == '0) return f3[1] ? a : 32'hffff_ffff;
    if (f3[0]) return f3[1] ? a % b : a / b;
    if (a == 32'h8000_0000 && b == 32'hffff_ffff) return f3[1] ? 32'h0 : a;
    return f3[1] ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
  endfunction

  // Reference decode and execute that also updates the register model
  task automatic model_exec(input rv_pkg::insn_t insn);
    logic [2:0] f3;
    logic [6:0] f7;
    rv_pkg::word_t a;
    logic legal;
    logic writes;
    rv_pkg::word_t r;
    f3 = insn[14:12];
    f7 = insn[31:25];
    a = model_regs[insn[19:15]];
    legal = 1'b0;
    writes = 1'b1;
    r = '0;
    case (insn[6:0])
      `RV_OPC_LUI: begin
        legal = 1'b1;
        r = {insn[31:12], 12'h000};
      end
      `RV_OPC_REG_IMM: begin
        legal = (f3 == 3'd1) ? (f7 == 7'h00) : (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
        r = alu_model(f3, f3 == 3'd5 && f7[5], a, {{20{insn[31]}}, insn[31:20]});
      end
      `RV_OPC_REG_REG: begin
        if (f7 == 7'h01) begin
          legal = f3[2];
          r = div_model(f3, a, model_regs[insn[24:20]]);
        end else begin
          legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
          r = alu_model(f3, f7[5], a, model_regs[insn[24:20]]);
        end
      end
      `RV_OPC_SYSTEM: begin
        writes = 1'b0;
        legal = (insn[31:7] == '0);
        if (legal) model_halt = 1'b1;
      end
      default: legal = 1'b0;
    endcase
    exp_ill = !legal;
    exp_wr = legal && writes && (insn[11:7] != 5'd0);
    exp_rd = insn[11:7];
    exp_data = r;
    if (exp_wr) model_regs[exp_rd] = r;
  endtask

  task automatic check_word(input string what, input rv_pkg::word_t exp, input rv_pkg::word_t act);
    test_checks++;
    if (exp !== act) begin
      test_errors++;
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_idx(input string what, input rv_pkg::reg_idx_t exp,
                           input rv_pkg::reg_idx_t act);
    test_checks++;
    if (exp !== act) begin
      test_errors++;
      $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    test_checks++;
    if (exp !== act) begin
      test_errors++;
      $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  // Check the previous instruction's report and present the next one
  task automatic step(input logic valid, input rv_pkg::insn_t insn);
    @(negedge clk);
    check_flag("o_wb_valid", exp_wr, o_wb_valid);
    if (exp_wr) begin
      check_idx("o_wb_rd", exp_rd, o_wb_rd);
      check_word("o_wb_data", exp_data, o_wb_data);
    end
    check_flag("o_illegal", exp_ill, o_illegal);
    check_flag("o_halt", model_halt, o_halt);
    i_insn_valid = valid;
    i_insn = insn;
    exp_wr = 1'b0;
    exp_ill = 1'b0;
    if (valid && !model_halt) model_exec(insn);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    step(1'b0, '0);
    $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    n_tests++;
    total_checks += test_checks;
    total_errors += test_errors;
  endtask

  // ADDI r, r, 0 reports each register on the writeback port
  task automatic read_back_all();
    for (int r = 1; r < 32; r++) begin
      step(1'b1, enc_i(12'h000, 5'(r), `RV_F3_ADD, 5'(r)));
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: no result after %0d cycles", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] bits;
    logic [2:0] f3;
    rv_pkg::reg_idx_t rd;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t last_rd;
    rst = 1'b1;
    i_insn_valid = 1'b0;
    i_insn = '0;
    lfsr = 32'h8d45_4e32;
    cycles = 0;
    n_tests = 0;
    total_checks = 0;
    total_errors = 0;
    model_halt = 1'b0;
    exp_wr = 1'b0;
    exp_ill = 1'b0;
    last_rd = '0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    begin_test("reset_state");
    read_back_all();
    for (int r = 1; r < 32; r++) begin
      bits = take_bits(20);
      if (take_bits(1)) step(1'b1, {bits[19:0], 5'(r), `RV_OPC_LUI});
      else step(1'b1, enc_i(bits[11:0], 5'd0, `RV_F3_ADD, 5'(r)));
    end
    end_test();

    begin_test("reg_reg");
    for (int i = 0; i < N_RR; i++) begin
      bits = take_bits(19);
      f3 = bits[2:0];
      rd = bits[7:3];
      // Half of the time read the register written just before
      rs1 = bits[8] ? last_rd : bits[13:9];
      bits[18] = bits[18] && (f3 == `RV_F3_ADD || f3 == `RV_F3_SR);
      step(1'b1, enc_r(bits[18] ? `RV_F7_ALT : `RV_F7_BASE, bits[17:14] + 5'd1, rs1, f3, rd));
      last_rd = rd;
    end
    step(1'b1, enc_r(`RV_F7_BASE, 5'd1, 5'd1, `RV_F3_ADD, 5'd0));
    step(1'b1, enc_r(`RV_F7_BASE, 5'd0, 5'd0, `RV_F3_OR, 5'd9));
    end_test();

    begin_test("reg_imm");
    for (int i = 0; i < N_RI; i++) begin
      bits = take_bits(26);
      f3 = bits[2:0];
      if (f3 == `RV_F3_SLL || f3 == `RV_F3_SR) bits[25:19] = {1'b0, bits[25] && f3[2], 5'b0};
      step(1'b1, enc_i(bits[25:14], bits[13:9], f3, bits[7:3]));
    end
    end_test();

    begin_test("divide");
    step(1'b1, {20'h80000, 5'd1, `RV_OPC_LUI});
    step(1'b1, enc_i(12'hfff, 5'd0, `RV_F3_ADD, 5'd2));
    step(1'b1, enc_i(12'h000, 5'd0, `RV_F3_ADD, 5'd3));
    // Overflow and zero divisor cases for each divide op
    for (int k = 4; k < 8; k++) begin
      step(1'b1, enc_r(`RV_F7_MULDIV, 5'd2, 5'd1, 3'(k), 5'd4));
      step(1'b1, enc_r(`RV_F7_MULDIV, 5'd3, 5'd1, 3'(k), 5'd5));
      step(1'b1, enc_r(`RV_F7_MULDIV, 5'd3, 5'd2, 3'(k), 5'd6));
    end
    for (int i = 0; i < N_DIV; i++) begin
      bits = take_bits(17);
      step(1'b1, enc_r(`RV_F7_MULDIV, bits[16:12], bits[11:7], {1'b1, bits[1:0]}, bits[6:2]));
    end
    end_test();

    begin_test("illegal");
    for (int i = 0; i < N_ILL; i++) begin
      bits = take_bits(32);
      case (take_bits(3))
        0: step(1'b1, {7'h01, bits[24:15], 1'b0, bits[13:12], bits[11:7], `RV_OPC_REG_REG});
        1: step(1'b1, {bits[31:7], 7'b1100011});
        2: step(1'b1, {bits[31:7], 7'b0000011});
        3: step(1'b1, {bits[31:7], 7'b0100011});
        4: step(1'b1, {bits[31:7], 7'b0010111});
        5: step(1'b1, {bits[31:7], 7'b1101111});
        6: step(1'b1, {`RV_F7_ALT, bits[24:15], `RV_F3_SLL, bits[11:7], `RV_OPC_REG_IMM});
        default: step(1'b1, {bits[31:8], 1'b1, `RV_OPC_SYSTEM});
      endcase
    end
    read_back_all();
    end_test();

    begin_test("halt");
    step(1'b1, {25'd0, `RV_OPC_SYSTEM});
    for (int i = 0; i < N_HALT; i++) begin
      step(1'b1, take_bits(32));
    end
    end_test();

    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
